/* logic/rv_pkg.sv */
package rv_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int COUNT_W    = 32;

	// major opcodes the core understands
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10,
		ALU_NOP    = 4'd11
	} alu_op_e;

	// wen is never set for x0
	typedef struct packed {
		logic                  wen;
		logic [REG_ADDR_W-1:0] rd;
	} dst_t;

	typedef struct packed {
		alu_op_e         alu_op;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		dst_t            dst;
	} exec_uop_t;

	typedef struct packed {
		dst_t            dst;
		logic [XLEN-1:0] data;
	} retire_t;

endpackage

/* logic/rv_stage_reg.sv */
`timescale 1ns/1ps

module rv_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset_i,
	input  logic     valid_i,
	output logic     ready_o,
	input  payload_t data_i,
	output logic     valid_o,
	input  logic     ready_i,
	output payload_t data_o
);

	logic     valid_q;
	payload_t data_q;

	// free when empty or drained this cycle
	assign ready_o = ~valid_q | ready_i;
	assign valid_o = valid_q;
	assign data_o  = data_q;

	always_ff @(posedge clock) begin
		if (reset_i) begin
			valid_q <= 1'b0;
		end else if (ready_o) begin
			valid_q <= valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (valid_i && ready_o) begin
			data_q <= data_i;
		end
	end

	// a stalled output must hold its record until taken
	assert property (@(posedge clock) disable iff (reset_i)
		valid_o && !ready_i |=> valid_o && $stable(data_o));

	assert property (@(posedge clock) reset_i |=> !valid_o);

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
	input  logic                  clock,
	input  logic                  reset_i,
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	output logic [XLEN-1:0]       rs1_data_o,
	output logic [XLEN-1:0]       rs2_data_o,
	input  logic                  wr_en_i,
	input  dst_t                  wr_dst_i,
	input  logic [XLEN-1:0]       wr_data_i
);

	// x0 has no storage
	logic [XLEN-1:0] regs_q [1:31];

	always_ff @(posedge clock) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i && wr_dst_i.wen && wr_dst_i.rd != '0) begin
			regs_q[wr_dst_i.rd] <= wr_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

	// the decoder must never mark x0 as a destination
	assert property (@(posedge clock) disable iff (reset_i)
		wr_en_i && wr_dst_i.wen |-> wr_dst_i.rd != '0);

endmodule

/* logic/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
	input  logic [31:0]           inst_i,
	input  logic [XLEN-1:0]       rs1_data_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	output logic                  rs1_ren_o,
	output logic                  rs2_ren_o,
	output exec_uop_t             uop_o
);

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_u;

	assign opcode     = inst_i[6:0];
	assign rd         = inst_i[11:7];
	assign funct3     = inst_i[14:12];
	assign funct7     = inst_i[31:25];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];
	assign imm_i      = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u      = {inst_i[31:12], 12'b0};

	// alt picks sub / arithmetic shift
	function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		// unsupported opcodes fall through as a no-op
		uop_o     = '{alu_op: ALU_NOP, a: '0, b: '0, dst: '0};
		rs1_ren_o = 1'b0;
		rs2_ren_o = 1'b0;
		case (opcode)
			OPC_OP: begin
				uop_o.alu_op = f3_to_alu(funct3, funct7[5]);
				uop_o.a      = rs1_data_i;
				uop_o.b      = rs2_data_i;
				uop_o.dst    = '{wen: rd != '0, rd: rd};
				rs1_ren_o    = 1'b1;
				rs2_ren_o    = 1'b1;
			end
			OPC_OP_IMM: begin
				// only the shift-right immediate has an alternate form
				uop_o.alu_op = f3_to_alu(funct3, funct3 == 3'b101 && funct7[5]);
				uop_o.a      = rs1_data_i;
				uop_o.b      = imm_i;
				uop_o.dst    = '{wen: rd != '0, rd: rd};
				rs1_ren_o    = 1'b1;
			end
			OPC_LUI: begin
				uop_o.alu_op = ALU_PASS_B;
				uop_o.b      = imm_u;
				uop_o.dst    = '{wen: rd != '0, rd: rd};
			end
			default: ;
		endcase
	end

endmodule

/* logic/rv_hazard_ctrl.sv */
`timescale 1ns/1ps

module rv_hazard_ctrl import rv_pkg::*; (
	input  logic                  clock,
	input  logic                  reset_i,
	input  logic                  inst_valid_i,
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	input  logic                  rs1_ren_i,
	input  logic                  rs2_ren_i,
	input  logic                  ex_valid_i,
	input  dst_t                  ex_dst_i,
	input  logic                  wb_valid_i,
	input  dst_t                  wb_dst_i,
	input  logic                  issue_ready_i,
	output logic                  inst_ready_o,
	output logic                  issue_valid_o,
	output logic                  stall_o
);

	typedef enum logic {
		HZ_RUN,
		HZ_WAIT_WB
	} hz_state_e;

	hz_state_e state_q;
	hz_state_e state_d;
	logic      ex_wr;
	logic      wb_wr;
	logic      rs1_hit;
	logic      rs2_hit;
	logic      conflict;

	// a stage only matters if it will write a register
	assign ex_wr    = ex_valid_i & ex_dst_i.wen;
	assign wb_wr    = wb_valid_i & wb_dst_i.wen;
	assign rs1_hit  = rs1_ren_i & ((ex_wr & (ex_dst_i.rd == rs1_addr_i))
		| (wb_wr & (wb_dst_i.rd == rs1_addr_i)));
	assign rs2_hit  = rs2_ren_i & ((ex_wr & (ex_dst_i.rd == rs2_addr_i))
		| (wb_wr & (wb_dst_i.rd == rs2_addr_i)));
	assign conflict = rs1_hit | rs2_hit;

	assign inst_ready_o  = issue_ready_i & ~conflict;
	assign issue_valid_o = inst_valid_i & ~conflict;
	assign stall_o       = (state_q == HZ_WAIT_WB);

	always_comb begin
		state_d = state_q;
		case (state_q)
			HZ_RUN:     if (inst_valid_i && conflict) state_d = HZ_WAIT_WB;
			HZ_WAIT_WB: if (!(inst_valid_i && conflict)) state_d = HZ_RUN;
			default:    state_d = HZ_RUN;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state_q <= HZ_RUN;
		end else begin
			state_q <= state_d;
		end
	end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	input  exec_uop_t uop_i,
	output retire_t   result_o
);

	logic [4:0]      shamt;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;

	assign a     = uop_i.a;
	assign b     = uop_i.b;
	assign shamt = b[4:0];

	always_comb begin
		result_o.dst = uop_i.dst;
		case (uop_i.alu_op)
			ALU_ADD:    result_o.data = a + b;
			ALU_SUB:    result_o.data = a - b;
			ALU_SLL:    result_o.data = a << shamt;
			ALU_SLT:    result_o.data = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:   result_o.data = {31'b0, a < b};
			ALU_XOR:    result_o.data = a ^ b;
			ALU_SRL:    result_o.data = a >> shamt;
			// keep the sign bit while shifting
			ALU_SRA:    result_o.data = $unsigned($signed(a) >>> shamt);
			ALU_OR:     result_o.data = a | b;
			ALU_AND:    result_o.data = a & b;
			// lui carries its value in b
			ALU_PASS_B: result_o.data = b;
			default:    result_o.data = '0;
		endcase
	end

endmodule

/* logic/rv_perf_counter.sv */
`timescale 1ns/1ps

module rv_perf_counter import rv_pkg::*; (
	input  logic               clock,
	input  logic               reset_i,
	input  logic               retire_fire_i,
	input  logic               stall_i,
	output logic [COUNT_W-1:0] retired_count_o,
	output logic [COUNT_W-1:0] stall_count_o
);

	// both counters simply wrap
	always_ff @(posedge clock) begin
		if (reset_i) begin
			retired_count_o <= '0;
			stall_count_o   <= '0;
		end else begin
			if (retire_fire_i) begin
				retired_count_o <= retired_count_o + 1'b1;
			end
			if (stall_i) begin
				stall_count_o <= stall_count_o + 1'b1;
			end
		end
	end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
	input  logic               clock,
	input  logic               reset_i,
	input  logic [31:0]        inst_i,
	input  logic               inst_valid_i,
	output logic               inst_ready_o,
	output retire_t            retire_o,
	output logic               retire_valid_o,
	input  logic               retire_ready_i,
	output logic [COUNT_W-1:0] retired_count_o,
	output logic [COUNT_W-1:0] stall_count_o
);

	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic                  rs1_ren;
	logic                  rs2_ren;
	exec_uop_t             dec_uop;
	exec_uop_t             ex_uop;
	retire_t               alu_result;
	logic                  issue_valid;
	logic                  issue_ready;
	logic                  ex_valid;
	logic                  wb_ready;
	logic                  stall;
	logic                  retire_fire;

	// the register file updates on the retire handshake
	assign retire_fire = retire_valid_o & retire_ready_i;

	rv_decoder u_decoder (
		.inst_i     (inst_i),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_ren_o  (rs1_ren),
		.rs2_ren_o  (rs2_ren),
		.uop_o      (dec_uop)
	);

	rv_regfile u_regfile (
		.clock      (clock),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wr_en_i    (retire_fire),
		.wr_dst_i   (retire_o.dst),
		.wr_data_i  (retire_o.data)
	);

	rv_hazard_ctrl u_hazard_ctrl (
		.clock         (clock),
		.reset_i       (reset_i),
		.inst_valid_i  (inst_valid_i),
		.rs1_addr_i    (rs1_addr),
		.rs2_addr_i    (rs2_addr),
		.rs1_ren_i     (rs1_ren),
		.rs2_ren_i     (rs2_ren),
		.ex_valid_i    (ex_valid),
		.ex_dst_i      (ex_uop.dst),
		.wb_valid_i    (retire_valid_o),
		.wb_dst_i      (retire_o.dst),
		.issue_ready_i (issue_ready),
		.inst_ready_o  (inst_ready_o),
		.issue_valid_o (issue_valid),
		.stall_o       (stall)
	);

	rv_stage_reg #(.payload_t(exec_uop_t)) ex_stage (
		.clock   (clock),
		.reset_i (reset_i),
		.valid_i (issue_valid),
		.ready_o (issue_ready),
		.data_i  (dec_uop),
		.valid_o (ex_valid),
		.ready_i (wb_ready),
		.data_o  (ex_uop)
	);

	rv_alu u_alu (
		.uop_i    (ex_uop),
		.result_o (alu_result)
	);

	rv_stage_reg #(.payload_t(retire_t)) wb_stage (
		.clock   (clock),
		.reset_i (reset_i),
		.valid_i (ex_valid),
		.ready_o (wb_ready),
		.data_i  (alu_result),
		.valid_o (retire_valid_o),
		.ready_i (retire_ready_i),
		.data_o  (retire_o)
	);

	rv_perf_counter u_perf_counter (
		.clock           (clock),
		.reset_i         (reset_i),
		.retire_fire_i   (retire_fire),
		.stall_i         (stall),
		.retired_count_o (retired_count_o),
		.stall_count_o   (stall_count_o)
	);

endmodule

/* verif/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker import rv_pkg::*; (
	input  logic        clock,
	input  logic        reset_i,
	input  logic [31:0] inst_i,
	input  logic        inst_valid_i,
	input  logic        inst_ready_i,
	input  retire_t     retire_i,
	input  logic        retire_valid_i,
	input  logic        retire_ready_i,
	output int          errors_o,
	output int          accepted_o,
	output int          matched_o,
	output int          pending_o
);

	// architectural state as seen in program order
	logic [31:0] model [0:31];
	retire_t     expect_q [$];

	// RV32I semantics of the kept instructions, straight from the ISA rules
	function automatic retire_t ref_exec(input logic [31:0] inst, input logic [31:0] s1,
		input logic [31:0] s2);
		retire_t            rec;
		logic [31:0]        b;
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		logic [4:0]         sh;
		logic               is_reg;
		logic               known;
		rec    = '0;
		is_reg = (inst[6:0] == OPC_OP);
		known  = is_reg || inst[6:0] == OPC_OP_IMM || inst[6:0] == OPC_LUI;
		b      = is_reg ? s2 : {{20{inst[31]}}, inst[31:20]};
		sa     = s1;
		sb     = b;
		sh     = b[4:0];
		if (inst[6:0] == OPC_LUI) begin
			rec.data = {inst[31:12], 12'h000};
		end else if (known) begin
			case (inst[14:12])
				3'd0: begin
					// only the register form has sub
					if (is_reg && inst[30]) begin
						rec.data = s1 - b;
					end else begin
						rec.data = s1 + b;
					end
				end
				3'd1: rec.data = s1 << sh;
				3'd2: rec.data = (sa < sb) ? 32'd1 : 32'd0;
				3'd3: rec.data = (s1 < b) ? 32'd1 : 32'd0;
				3'd4: rec.data = s1 ^ b;
				3'd5: begin
					if (inst[30]) begin
						rec.data = sa >>> sh;
					end else begin
						rec.data = s1 >> sh;
					end
				end
				3'd6: rec.data = s1 | b;
				default: rec.data = s1 & b;
			endcase
		end
		// unknown opcodes and rd = x0 write nothing
		rec.dst.wen = known && inst[11:7] != 5'd0;
		rec.dst.rd  = rec.dst.wen ? inst[11:7] : 5'd0;
		return rec;
	endfunction

	always @(posedge clock) begin
		retire_t got;
		retire_t want;
		retire_t rec;
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				model[i] = '0;
			end
			expect_q.delete();
			errors_o   = 0;
			accepted_o = 0;
			matched_o  = 0;
		end else begin
			if (retire_valid_i && retire_ready_i) begin
				got = retire_i;
				if (expect_q.size() == 0) begin
					$display("retire at %0t with no instruction outstanding", $time);
					errors_o++;
				end else begin
					want = expect_q.pop_front();
					matched_o++;
					if (got !== want) begin
						$display("MISMATCH at %0t: got wen/rd/data %0b/%0d/%08h, expected %0b/%0d/%08h",
							$time, got.dst.wen, got.dst.rd, got.data,
							want.dst.wen, want.dst.rd, want.data);
						errors_o++;
					end
				end
			end
			if (inst_valid_i && inst_ready_i) begin
				rec = ref_exec(inst_i, model[inst_i[19:15]], model[inst_i[24:20]]);
				expect_q.push_back(rec);
				accepted_o++;
				if (rec.dst.wen) begin
					model[rec.dst.rd] = rec.data;
				end
			end
		end
	end

	assign pending_o = accepted_o - matched_o;

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

	logic               clock = 1'b0;
	logic               reset_i;
	logic [31:0]        inst_i;
	logic               inst_valid_i;
	logic               inst_ready_o;
	retire_t            retire_o;
	logic               retire_valid_o;
	logic               retire_ready_i = 1'b1;
	logic [COUNT_W-1:0] retired_count_o;
	logic [COUNT_W-1:0] stall_count_o;
	logic               bp_en;
	logic               timed_out;
	int                 chk_errors;
	int                 chk_accepted;
	int                 chk_matched;
	int                 chk_pending;
	int                 tb_errors;
	int                 errs_seen;

	always #4 clock = ~clock;

	// random back-pressure on the retire port
	always @(negedge clock) begin
		logic [31:0] r;
		r = $urandom();
		retire_ready_i = bp_en ? r[0] : 1'b1;
	end

	rv_core rv_core_inst (
		.clock           (clock),
		.reset_i         (reset_i),
		.inst_i          (inst_i),
		.inst_valid_i    (inst_valid_i),
		.inst_ready_o    (inst_ready_o),
		.retire_o        (retire_o),
		.retire_valid_o  (retire_valid_o),
		.retire_ready_i  (retire_ready_i),
		.retired_count_o (retired_count_o),
		.stall_count_o   (stall_count_o)
	);

	rv_core_checker rv_core_checker_inst (
		.clock          (clock),
		.reset_i        (reset_i),
		.inst_i         (inst_i),
		.inst_valid_i   (inst_valid_i),
		.inst_ready_i   (inst_ready_o),
		.retire_i       (retire_o),
		.retire_valid_i (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.errors_o       (chk_errors),
		.accepted_o     (chk_accepted),
		.matched_o      (chk_matched),
		.pending_o      (chk_pending)
	);

	function automatic logic [31:0] rtype_word(input logic [2:0] f3, input logic alt,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] itype_word(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, OPC_LUI};
	endfunction

	function automatic logic [31:0] random_reg_op();
		logic [31:0] r;
		r = $urandom();
		// alternate encoding only exists for sub and sra
		return rtype_word(r[2:0], r[3] && (r[2:0] == 3'b000 || r[2:0] == 3'b101),
			r[8:4], r[13:9], r[18:14]);
	endfunction

	function automatic logic [31:0] random_imm_op();
		logic [31:0] r;
		logic [11:0] imm;
		r   = $urandom();
		imm = r[31:20];
		if (r[2:0] == 3'b001) begin
			imm = {7'b0, r[24:20]};
		end else if (r[2:0] == 3'b101) begin
			imm = {1'b0, r[19], 5'b0, r[24:20]};
		end
		return itype_word(r[2:0], r[7:3], r[12:8], imm);
	endfunction

	function automatic logic [31:0] random_mix();
		int unsigned pick;
		logic [31:0] r;
		pick = $urandom_range(99, 0);
		r    = $urandom();
		if (pick < 50) begin
			return random_reg_op();
		end else if (pick < 85) begin
			return random_imm_op();
		end
		return lui_word(r[4:0], r[31:12]);
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_inst(input logic [31:0] inst);
		int waited;
		int start;
		waited       = 0;
		start        = chk_accepted;
		inst_i       = inst;
		inst_valid_i = 1'b1;
		while (chk_accepted == start && !timed_out) begin
			@(negedge clock);
			waited++;
			if (waited >= 1000) begin
				$display("timeout: intake never accepted instruction %08h", inst);
				timed_out = 1'b1;
			end
		end
		inst_valid_i = 1'b0;
	endtask

	task automatic drain_pipe();
		int waited;
		waited = 0;
		while (chk_pending != 0 && !timed_out) begin
			@(negedge clock);
			waited++;
			if (waited >= 4000) begin
				$display("timeout: %0d instructions never retired", chk_pending);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic expect_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, want);
			tb_errors++;
		end
	endtask

	task automatic close_test(input string name);
		int total;
		drain_pipe();
		total = chk_errors + tb_errors;
		if (total == errs_seen && !timed_out) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d new errors", name, total - errs_seen);
		end
		errs_seen = total;
	endtask

	task automatic preload_regs();
		logic [31:0] r;
		for (int n = 1; n < 32; n++) begin
			r = $urandom();
			send_inst(lui_word(5'(n), r[31:12]));
			send_inst(itype_word(3'b000, 5'(n), 5'(n), r[11:0]));
		end
	endtask

	// or x0, xn, x0 exposes xn on the retire port without writing
	task automatic read_back_regs();
		for (int n = 0; n < 32; n++) begin
			send_inst(rtype_word(3'b110, 1'b0, 5'd0, 5'(n), 5'd0));
		end
	endtask

	initial begin
		logic [31:0] stall_before;
		logic [31:0] r;
		void'($urandom(32'hf6ed_233a));
		reset_i      = 1'b1;
		inst_i       = '0;
		inst_valid_i = 1'b0;
		bp_en        = 1'b0;
		timed_out    = 1'b0;
		tb_errors    = 0;
		errs_seen    = 0;
		repeat (10) @(negedge clock);
		reset_i = 1'b0;
		@(negedge clock);

		expect_value("retire_valid_o", {31'b0, retire_valid_o}, 32'd0);
		expect_value("retired_count_o", retired_count_o, 32'd0);
		expect_value("stall_count_o", stall_count_o, 32'd0);
		close_test("reset_state");

		preload_regs();
		for (int n = 0; n < 200; n++) begin
			send_inst(random_reg_op());
		end
		close_test("reg_reg_random");

		for (int n = 0; n < 150; n++) begin
			r = $urandom();
			send_inst(r[0] ? random_imm_op() : lui_word(r[5:1], r[31:12]));
		end
		send_inst(itype_word(3'b000, 5'd0, 5'd3, 12'd77));
		send_inst(rtype_word(3'b000, 1'b0, 5'd8, 5'd0, 5'd0));
		close_test("imm_and_lui");

		// each instruction needs the previous result
		stall_before = stall_count_o;
		for (int n = 0; n < 20; n++) begin
			send_inst(itype_word(3'b000, 5'd5, 5'd5, 12'd1));
		end
		for (int n = 0; n < 10; n++) begin
			send_inst(rtype_word(3'b000, 1'b0, 5'd6, 5'd5, 5'd6));
			send_inst(rtype_word(3'b000, 1'b1, 5'd5, 5'd6, 5'd5));
		end
		drain_pipe();
		if (stall_count_o <= stall_before) begin
			$display("MISMATCH at %0t: stall_count_o stayed at %0d over a dependent chain",
				$time, stall_count_o);
			tb_errors++;
		end
		close_test("dep_chain");

		bp_en = 1'b1;
		for (int n = 0; n < 200; n++) begin
			send_inst(random_mix());
		end
		drain_pipe();
		bp_en = 1'b0;
		expect_value("retired_count_o", retired_count_o, chk_accepted);
		close_test("backpressure");

		// load, branch, jal, auipc and system opcodes
		send_inst({25'($urandom() >> 7), 7'b0000011});
		send_inst({25'($urandom() >> 7), 7'b1100011});
		send_inst({25'($urandom() >> 7), 7'b1101111});
		send_inst({25'($urandom() >> 7), 7'b0010111});
		send_inst({25'($urandom() >> 7), 7'b1110011});
		read_back_regs();
		close_test("unsupported");

		if (chk_pending != 0) begin
			$display("%0d expected records were never retired", chk_pending);
			tb_errors++;
		end
		$display("summary: %0d accepted, %0d checked, %0d errors",
			chk_accepted, chk_matched, chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* build.f */
logic/rv_pkg.sv
logic/rv_stage_reg.sv
logic/rv_regfile.sv
logic/rv_decoder.sv
logic/rv_hazard_ctrl.sv
logic/rv_alu.sv
logic/rv_perf_counter.sv
logic/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module rv_core_tb -o rv_core_sim

out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
	exit 0
else
	exit 1
fi
